// ==== design/gpioRegs.sv ====
`timescale 1ns/1ps

module gpioRegs
(
	input  logic           clock,
	input  logic           rst_i,
	input  logic           tickUs_i,
	input  logic [31:0]    mmioAddr_i,
	input  mmioPkg::memOpm mmioOpm_i,
	input  logic [31:0]    mmioData_i,
	input  logic [31:0]    gpioPins_i,
	output logic [31:0]    mmioData_o,
	output mmioPkg::memOk  mmioOk_o,
	output logic [31:0]    gpioPins_o,
	output logic [31:0]    gpioDir_o
);

	logic [31:0] gpioOut;
	logic [31:0] gpioDir;
	logic [31:0] usCount;
	logic [31:0] readData;

	logic addrHit;
	logic claim;
	logic claimPhase;
	logic doWrite;

	// register select and read data
	always_comb
	begin
		addrHit  = 1'b1;
		readData = '0;
		case (mmioAddr_i)
			mmioPkg::gpioOutAddr: readData = gpioOut;
			mmioPkg::gpioDirAddr: readData = gpioDir;
			// only pins configured as inputs are visible
			mmioPkg::gpioInAddr:  readData = gpioPins_i & ~gpioDir;
			mmioPkg::usCountAddr: readData = usCount;
			default:              addrHit  = 1'b0;
		endcase
	end

	assign claim = addrHit && (mmioOpm_i != mmioPkg::opIdle);

	// hold in the first cycle, ok afterwards
	always_comb
	begin
		if (!claim)
		begin
			mmioOk_o = mmioPkg::okReady;
		end
		else if (claimPhase)
		begin
			mmioOk_o = mmioPkg::okOk;
		end
		else
		begin
			mmioOk_o = mmioPkg::okHold;
		end
	end

	assign mmioData_o = claim ? readData : '0;

	assign doWrite = claim && claimPhase && (mmioOpm_i == mmioPkg::opWrite);

	always_ff @(posedge clock)
	begin
		if (rst_i)
		begin
			claimPhase <= 1'b0;
			gpioOut    <= '0;
			gpioDir    <= '0;
			usCount    <= '0;
		end
		else
		begin
			claimPhase <= claim;

			if (tickUs_i)
			begin
				usCount <= usCount + 32'd1;
			end

			if (doWrite && (mmioAddr_i == mmioPkg::gpioOutAddr))
			begin
				gpioOut <= mmioData_i;
			end
			if (doWrite && (mmioAddr_i == mmioPkg::gpioDirAddr))
			begin
				gpioDir <= mmioData_i;
			end
		end
	end

	assign gpioPins_o = gpioOut;
	assign gpioDir_o  = gpioDir;

	// an idle bus is never acknowledged
	noOkWhenIdle: assert property (
		@(posedge clock) disable iff (rst_i)
		(mmioOpm_i == mmioPkg::opIdle) |-> (mmioOk_o != mmioPkg::okOk)
	);

endmodule

// ==== design/mmioPkg.sv ====
package mmioPkg;

	// bus operation code, held level for the whole request
	typedef enum logic [4:0]
	{
		opIdle  = 5'h00,
		opRead  = 5'h01,
		opWrite = 5'h02
	} memOpm;

	// response status from a peripheral or the mux
	typedef enum logic [1:0]
	{
		okReady = 2'b00,
		okOk    = 2'b01,
		okHold  = 2'b10,
		okFault = 2'b11
	} memOk;

	// peripheral register map
	localparam logic [31:0] gpioOutAddr  = 32'hF000E000;
	localparam logic [31:0] gpioDirAddr  = 32'hF000E004;
	localparam logic [31:0] gpioInAddr   = 32'hF000E008;
	localparam logic [31:0] usCountAddr  = 32'hF000E00C;
	localparam logic [31:0] segValueAddr = 32'hF000E010;

	// prescaler ratios, scaled down for simulation
	localparam int usDivide = 8;
	localparam int msDivide = 16;

	// cycles an unclaimed request waits for its miss answer
	localparam int missLimit = 15;

	localparam logic [15:0] timerExcCode = 16'hC001;

	localparam int usCountWidth   = $clog2(usDivide);
	localparam int msCountWidth   = $clog2(msDivide);
	localparam int missCountWidth = $clog2(missLimit + 1);

	typedef logic [usCountWidth-1:0]   usCountT;
	typedef logic [msCountWidth-1:0]   msCountT;
	typedef logic [missCountWidth-1:0] missCountT;

	// terminal counts for the counters above
	localparam usCountT   usLast   = usCountT'(usDivide - 1);
	localparam msCountT   msLast   = msCountT'(msDivide - 1);
	localparam missCountT missLast = missCountT'(missLimit);

endpackage

// ==== design/mmioResponseMux.sv ====
`timescale 1ns/1ps

module mmioResponseMux
(
	input  logic           clock,
	input  logic           rst_i,
	input  mmioPkg::memOpm mmioOpm_i,
	input  logic           tickMs_i,
	input  logic [31:0]    gpioData_i,
	input  mmioPkg::memOk  gpioOk_i,
	input  logic [31:0]    segData_i,
	input  mmioPkg::memOk  segOk_i,
	output logic [31:0]    mmioData_o,
	output mmioPkg::memOk  mmioOk_o,
	output logic [63:0]    busExc_o
);

	mmioPkg::missCountT missCount;
	mmioPkg::missCountT missCountNext;

	logic claimed;
	logic missDone;

	assign claimed  = (gpioOk_i != mmioPkg::okReady) || (segOk_i != mmioPkg::okReady);
	assign missDone = (missCount == mmioPkg::missLast);

	// first claiming peripheral wins and the miss path comes last
	always_comb
	begin
		mmioData_o = '0;
		mmioOk_o   = mmioPkg::okReady;
		if (gpioOk_i != mmioPkg::okReady)
		begin
			mmioData_o = gpioData_i;
			mmioOk_o   = gpioOk_i;
		end
		else if (segOk_i != mmioPkg::okReady)
		begin
			mmioData_o = segData_i;
			mmioOk_o   = segOk_i;
		end
		else if (mmioOpm_i != mmioPkg::opIdle)
		begin
			// nobody home so answer with zero once the wait runs out
			mmioOk_o = missDone ? mmioPkg::okOk : mmioPkg::okHold;
		end
	end

	always_comb
	begin
		if ((mmioOpm_i == mmioPkg::opIdle) || claimed)
		begin
			missCountNext = '0;
		end
		else if (missDone)
		begin
			missCountNext = missCount;
		end
		else
		begin
			missCountNext = missCount + 1'b1;
		end
	end

	always_ff @(posedge clock)
	begin
		if (rst_i)
		begin
			missCount <= '0;
			busExc_o  <= '0;
		end
		else
		begin
			missCount <= missCountNext;
			// timer exception for one cycle after the ms tick
			busExc_o  <= tickMs_i ? {48'h0, mmioPkg::timerExcCode} : 64'h0;
		end
	end

	// count stays at the limit and never wraps while the miss is open
	missBounded: assert property (
		@(posedge clock) disable iff (rst_i)
		(missDone && (mmioOpm_i != mmioPkg::opIdle) && !claimed) |=> missDone
	);

endmodule

// ==== design/peripheralCore.sv ====
`timescale 1ns/1ps

module peripheralCore
(
	input  logic           clock,
	input  logic           rst_i,
	input  logic [31:0]    mmioAddr_i,
	input  mmioPkg::memOpm mmioOpm_i,
	input  logic [31:0]    mmioData_i,
	input  logic [31:0]    gpioPins_i,
	output logic [31:0]    mmioData_o,
	output mmioPkg::memOk  mmioOk_o,
	output logic [63:0]    busExc_o,
	output logic [31:0]    gpioPins_o,
	output logic [31:0]    gpioDir_o,
	output logic [7:0]     segChar_o,
	output logic [7:0]     segSeg_o
);

	logic tickUs;
	logic tickMs;

	// peripheral responses into the mux
	logic [31:0]   gpioData;
	mmioPkg::memOk gpioOk;
	logic [31:0]   segData;
	mmioPkg::memOk segOk;

	timerPulses u_timerPulses
	(
		.clock    (clock),
		.rst_i    (rst_i),
		.tickUs_o (tickUs),
		.tickMs_o (tickMs)
	);

	gpioRegs u_gpioRegs
	(
		.clock      (clock),
		.rst_i      (rst_i),
		.tickUs_i   (tickUs),
		.mmioAddr_i (mmioAddr_i),
		.mmioOpm_i  (mmioOpm_i),
		.mmioData_i (mmioData_i),
		.gpioPins_i (gpioPins_i),
		.mmioData_o (gpioData),
		.mmioOk_o   (gpioOk),
		.gpioPins_o (gpioPins_o),
		.gpioDir_o  (gpioDir_o)
	);

	sevenSegScan u_sevenSegScan
	(
		.clock      (clock),
		.rst_i      (rst_i),
		.tickMs_i   (tickMs),
		.mmioAddr_i (mmioAddr_i),
		.mmioOpm_i  (mmioOpm_i),
		.mmioData_i (mmioData_i),
		.mmioData_o (segData),
		.mmioOk_o   (segOk),
		.segChar_o  (segChar_o),
		.segSeg_o   (segSeg_o)
	);

	mmioResponseMux u_mmioResponseMux
	(
		.clock      (clock),
		.rst_i      (rst_i),
		.mmioOpm_i  (mmioOpm_i),
		.tickMs_i   (tickMs),
		.gpioData_i (gpioData),
		.gpioOk_i   (gpioOk),
		.segData_i  (segData),
		.segOk_i    (segOk),
		.mmioData_o (mmioData_o),
		.mmioOk_o   (mmioOk_o),
		.busExc_o   (busExc_o)
	);

endmodule

// ==== design/sevenSegScan.sv ====
`timescale 1ns/1ps

module sevenSegScan
(
	input  logic           clock,
	input  logic           rst_i,
	input  logic           tickMs_i,
	input  logic [31:0]    mmioAddr_i,
	input  mmioPkg::memOpm mmioOpm_i,
	input  logic [31:0]    mmioData_i,
	output logic [31:0]    mmioData_o,
	output mmioPkg::memOk  mmioOk_o,
	output logic [7:0]     segChar_o,
	output logic [7:0]     segSeg_o
);

	logic [31:0] segValue;
	logic [2:0]  digitIdx;
	logic [3:0]  nibble;
	logic        scanOn;
	logic        claim;
	logic        claimPhase;

	// gfedcba, active high
	function automatic logic [6:0] hexFont(input logic [3:0] nib);
		case (nib)
			4'h0: hexFont = 7'h3F;
			4'h1: hexFont = 7'h06;
			4'h2: hexFont = 7'h5B;
			4'h3: hexFont = 7'h4F;
			4'h4: hexFont = 7'h66;
			4'h5: hexFont = 7'h6D;
			4'h6: hexFont = 7'h7D;
			4'h7: hexFont = 7'h07;
			4'h8: hexFont = 7'h7F;
			4'h9: hexFont = 7'h6F;
			4'hA: hexFont = 7'h77;
			4'hB: hexFont = 7'h7C;
			4'hC: hexFont = 7'h39;
			4'hD: hexFont = 7'h5E;
			4'hE: hexFont = 7'h79;
			default: hexFont = 7'h71;
		endcase
	endfunction

	assign claim = (mmioAddr_i == mmioPkg::segValueAddr) &&
		(mmioOpm_i != mmioPkg::opIdle);

	assign mmioOk_o = !claim ? mmioPkg::okReady :
		(claimPhase ? mmioPkg::okOk : mmioPkg::okHold);
	assign mmioData_o = claim ? segValue : '0;

	always_ff @(posedge clock)
	begin
		if (rst_i)
		begin
			claimPhase <= 1'b0;
			segValue   <= '0;
			digitIdx   <= '0;
			scanOn     <= 1'b0;
		end
		else
		begin
			claimPhase <= claim;
			if (claim && claimPhase && (mmioOpm_i == mmioPkg::opWrite))
			begin
				segValue <= mmioData_i;
			end
			// step to the next digit each millisecond
			if (tickMs_i)
			begin
				digitIdx <= digitIdx + 3'd1;
				scanOn   <= 1'b1;
			end
		end
	end

	assign nibble = segValue[{digitIdx, 2'b00} +: 4];

	// all digits dark until the scan starts
	assign segChar_o = scanOn ? ~(8'h01 << digitIdx) : 8'hFF;
	assign segSeg_o  = scanOn ? {1'b1, ~hexFont(nibble)} : 8'hFF;

	oneDigitAtMost: assert property (
		@(posedge clock) disable iff (rst_i)
		$onehot0(~segChar_o)
	);

endmodule

// ==== design/timerPulses.sv ====
`timescale 1ns/1ps

module timerPulses
(
	input  logic clock,
	input  logic rst_i,
	output logic tickUs_o,
	output logic tickMs_o
);

	mmioPkg::usCountT usCount;
	mmioPkg::msCountT msCount;

	logic usWrap;
	logic msWrap;

	// end of a microsecond period
	assign usWrap = (usCount == mmioPkg::usLast);

	// last microsecond of a millisecond period
	assign msWrap = (msCount == mmioPkg::msLast);

	always_ff @(posedge clock)
	begin
		if (rst_i)
		begin
			usCount  <= '0;
			msCount  <= '0;
			tickUs_o <= 1'b0;
			tickMs_o <= 1'b0;
		end
		else
		begin
			tickUs_o <= usWrap;
			tickMs_o <= usWrap && msWrap;

			if (usWrap)
			begin
				usCount <= '0;
				// millisecond counter steps once per microsecond
				if (msWrap)
				begin
					msCount <= '0;
				end
				else
				begin
					msCount <= msCount + 1'b1;
				end
			end
			else
			begin
				usCount <= usCount + 1'b1;
			end
		end
	end

	// a millisecond tick always lands on a microsecond tick
	msOnUsTick: assert property (
		@(posedge clock) disable iff (rst_i)
		$rose(tickMs_o) |-> tickUs_o
	);

endmodule

// ==== peripheralCore.f ====
design/mmioPkg.sv
design/timerPulses.sv
design/gpioRegs.sv
design/sevenSegScan.sv
design/mmioResponseMux.sv
design/peripheralCore.sv
testbench/clockGen.sv
testbench/peripheralCoreTb.sv

// ==== run.sh ====
#!/bin/sh
# build the testbench with Verilator, run it and scan the log for failure

rm -rf obj_dir \
	&& verilator --binary --timing --assert -f peripheralCore.f \
		--top-module peripheralCoreTb -o simPeripheralCore > build.log 2>&1 \
	&& ./obj_dir/simPeripheralCore > sim.log 2>&1 \
	|| { echo "build or simulation error, see build.log and sim.log"; exit 1; }

grep -q "Test failed" sim.log \
	&& { echo "simulation reported a failure, see sim.log"; exit 1; } \
	|| { echo "simulation passed"; exit 0; }

// ==== testbench/clockGen.sv ====
`timescale 1ns/1ps

module clockGen
#(
	parameter int periodNs    = 8,
	parameter int resetCycles = 3
)
(
	output logic clock,
	output logic rst_o
);

	initial
	begin
		clock = 1'b0;
		forever #(periodNs / 2) clock = ~clock;
	end

	// reset held for a few edges, then released on a rising edge
	initial
	begin
		rst_o = 1'b1;
		repeat (resetCycles) @(posedge clock);
		rst_o <= 1'b0;
	end

endmodule

// ==== testbench/peripheralCoreTb.sv ====
`timescale 1ns/1ps

module peripheralCoreTb;

	// roughly four times the length of all tests together
	localparam int cycleLimit = 6000;
	localparam int msPeriod   = mmioPkg::usDivide * mmioPkg::msDivide;
	localparam logic [31:0] unmappedAddr = 32'hF000E100;

	logic           clock;
	logic           rst;
	logic [31:0]    mmioAddr;
	mmioPkg::memOpm mmioOpm;
	logic [31:0]    mmioWrData;
	logic [31:0]    gpioPinsIn;
	logic [31:0]    mmioRdData;
	mmioPkg::memOk  mmioOk;
	logic [63:0]    busExc;
	logic [31:0]    gpioPinsOut;
	logic [31:0]    gpioDirOut;
	logic [7:0]     segChar;
	logic [7:0]     segSeg;

	// reference model and request bookkeeping
	logic [31:0] modelOut;
	logic [31:0] modelDir;
	logic [31:0] modelSeg;
	logic [31:0] expData;
	logic        checkData;
	logic        mapped;
	logic        seenExc;
	int          reqCycle;
	int          excGap;
	int          cycleCount;
	int          errors;
	int unsigned seed;
	string       testName;

	clockGen u_clockGen
	(
		.clock (clock),
		.rst_o (rst)
	);

	peripheralCore u_peripheralCore
	(
		.clock      (clock),
		.rst_i      (rst),
		.mmioAddr_i (mmioAddr),
		.mmioOpm_i  (mmioOpm),
		.mmioData_i (mmioWrData),
		.gpioPins_i (gpioPinsIn),
		.mmioData_o (mmioRdData),
		.mmioOk_o   (mmioOk),
		.busExc_o   (busExc),
		.gpioPins_o (gpioPinsOut),
		.gpioDir_o  (gpioDirOut),
		.segChar_o  (segChar),
		.segSeg_o   (segSeg)
	);

	// active-low segments with the decimal point dark
	function automatic logic [7:0] expectedSegments(input logic [3:0] nib);
		logic [6:0] lit;
		case (nib)
			4'h0: lit = 7'b0111111;
			4'h1: lit = 7'b0000110;
			4'h2: lit = 7'b1011011;
			4'h3: lit = 7'b1001111;
			4'h4: lit = 7'b1100110;
			4'h5: lit = 7'b1101101;
			4'h6: lit = 7'b1111101;
			4'h7: lit = 7'b0000111;
			4'h8: lit = 7'b1111111;
			4'h9: lit = 7'b1101111;
			4'hA: lit = 7'b1110111;
			4'hB: lit = 7'b1111100;
			4'hC: lit = 7'b0111001;
			4'hD: lit = 7'b1011110;
			4'hE: lit = 7'b1111001;
			default: lit = 7'b1110001;
		endcase
		expectedSegments = {1'b1, ~lit};
	endfunction

	function automatic int selectedDigit(input logic [7:0] sel);
		int idx;
		idx = 0;
		for (int i = 0; i < 8; i++)
		begin
			if (!sel[i])
			begin
				idx = i;
			end
		end
		return idx;
	endfunction

	task automatic reportValue(input string what, input logic [63:0] expected,
		input logic [63:0] actual);
		errors++;
		$display("CHECK FAILED %s / %s: expected %0h, actual %0h", testName, what,
			expected, actual);
	endtask

	// one request held until okOk and then one idle cycle
	task automatic busAccess(input string name, input logic [31:0] addr,
		input mmioPkg::memOpm op, input logic [31:0] wdata, input logic isMapped,
		input logic checkIt, input logic [31:0] expected, output logic [31:0] rdata);
		@(posedge clock);
		testName = name;
		mmioAddr   <= addr;
		mmioOpm    <= op;
		mmioWrData <= wdata;
		mapped     <= isMapped;
		checkData  <= checkIt;
		expData    <= expected;
		do
		begin
			@(negedge clock);
		end
		while (mmioOk != mmioPkg::okOk);
		rdata = mmioRdData;
		@(posedge clock);
		mmioOpm   <= mmioPkg::opIdle;
		checkData <= 1'b0;
	endtask

	task automatic writeReg(input string name, input logic [31:0] addr,
		input logic [31:0] data);
		logic [31:0] ignored;
		busAccess(name, addr, mmioPkg::opWrite, data, 1'b1, 1'b0, '0, ignored);
	endtask

	task automatic readCheck(input string name, input logic [31:0] addr,
		input logic [31:0] expected);
		logic [31:0] ignored;
		busAccess(name, addr, mmioPkg::opRead, '0, 1'b1, 1'b1, expected, ignored);
	endtask

	// waits out one exception pulse and returns the digit shown during it
	task automatic waitException(output int digit);
		do
		begin
			@(negedge clock);
		end
		while (busExc == 64'h0);
		digit = selectedDigit(segChar);
		@(negedge clock);
	endtask

	always_ff @(posedge clock)
	begin
		if (rst || (mmioOpm == mmioPkg::opIdle))
		begin
			reqCycle <= 0;
		end
		else
		begin
			reqCycle <= reqCycle + 1;
		end
	end

	always_ff @(posedge clock)
	begin
		if (rst)
		begin
			excGap  <= 0;
			seenExc <= 1'b0;
		end
		else if (busExc != 64'h0)
		begin
			excGap  <= 1;
			seenExc <= 1'b1;
		end
		else
		begin
			excGap <= excGap + 1;
		end
	end

	always @(posedge clock)
	begin
		cycleCount <= cycleCount + 1;
		if (cycleCount >= cycleLimit)
		begin
			$display("run stopped: no finish within %0d cycles", cycleLimit);
			$display("Test failed");
			$finish;
		end
	end

	idleReady: assert property (@(posedge clock) disable iff (rst)
		(mmioOpm == mmioPkg::opIdle) |-> (mmioOk == mmioPkg::okReady))
		else reportValue("idle status", 64'(mmioPkg::okReady), 64'($sampled(mmioOk)));

	holdFirst: assert property (@(posedge clock) disable iff (rst)
		(mmioOpm != mmioPkg::opIdle && mapped && reqCycle == 0) |->
		(mmioOk == mmioPkg::okHold))
		else reportValue("first cycle", 64'(mmioPkg::okHold), 64'($sampled(mmioOk)));

	okSecond: assert property (@(posedge clock) disable iff (rst)
		(mmioOpm != mmioPkg::opIdle && mapped && reqCycle == 1) |->
		(mmioOk == mmioPkg::okOk))
		else reportValue("second cycle", 64'(mmioPkg::okOk), 64'($sampled(mmioOk)));

	readData: assert property (@(posedge clock) disable iff (rst)
		(mmioOpm == mmioPkg::opRead && checkData && mmioOk == mmioPkg::okOk) |->
		(mmioRdData == expData))
		else reportValue("read data", 64'($sampled(expData)), 64'($sampled(mmioRdData)));

	pinsMatch: assert property (@(posedge clock) disable iff (rst)
		gpioPinsOut == modelOut)
		else reportValue("gpio pins", 64'($sampled(modelOut)), 64'($sampled(gpioPinsOut)));

	dirMatch: assert property (@(posedge clock) disable iff (rst)
		gpioDirOut == modelDir)
		else reportValue("gpio dir", 64'($sampled(modelDir)), 64'($sampled(gpioDirOut)));

	// unclaimed request waits out the miss limit
	missHold: assert property (@(posedge clock) disable iff (rst)
		(mmioOpm != mmioPkg::opIdle && !mapped && reqCycle < mmioPkg::missLimit) |->
		(mmioOk == mmioPkg::okHold))
		else reportValue("miss hold", 64'(mmioPkg::okHold), 64'($sampled(mmioOk)));

	missOk: assert property (@(posedge clock) disable iff (rst)
		(mmioOpm != mmioPkg::opIdle && !mapped && reqCycle == mmioPkg::missLimit) |->
		(mmioOk == mmioPkg::okOk))
		else reportValue("miss answer", 64'(mmioPkg::okOk), 64'($sampled(mmioOk)));

	missZero: assert property (@(posedge clock) disable iff (rst)
		(mmioOpm != mmioPkg::opIdle && !mapped && reqCycle == mmioPkg::missLimit) |->
		(mmioRdData == 32'h0))
		else reportValue("miss data", 64'h0, 64'($sampled(mmioRdData)));

	excValue: assert property (@(posedge clock) disable iff (rst)
		(busExc != 64'h0) |-> (busExc == {48'h0, mmioPkg::timerExcCode}))
		else reportValue("exception code", {48'h0, mmioPkg::timerExcCode}, $sampled(busExc));

	excSpacing: assert property (@(posedge clock) disable iff (rst)
		(busExc != 64'h0 && seenExc) |-> (excGap == msPeriod))
		else reportValue("exception spacing", 64'(msPeriod), 64'($sampled(excGap)));

	digitOneHot: assert property (@(posedge clock) disable iff (rst)
		(segChar != 8'hFF) |-> $onehot(~segChar))
		else
		begin
			errors++;
			$display("%s: more than one digit selected at once, select %b", testName,
				$sampled(segChar));
		end

	segPattern: assert property (@(posedge clock) disable iff (rst)
		(segChar != 8'hFF) |->
		(segSeg == expectedSegments(modelSeg[selectedDigit(segChar) * 4 +: 4])))
		else reportValue("segment pattern",
			64'(expectedSegments($sampled(modelSeg[selectedDigit(segChar) * 4 +: 4]))),
			64'($sampled(segSeg)));

	initial
	begin
		logic [31:0] outVal;
		logic [31:0] dirVal;
		logic [31:0] pinVal;
		logic [31:0] segVal;
		logic [31:0] usFirst;
		logic [31:0] usSecond;
		logic [31:0] ignored;
		int          startCycle;
		int          ticks;
		int          delta;
		int          digit;
		int          hits [8];

		seed = $urandom(32'hb08d);
		mmioAddr   = '0;
		mmioOpm    = mmioPkg::opIdle;
		mmioWrData = '0;
		gpioPinsIn = '0;
		modelOut   = '0;
		modelDir   = '0;
		modelSeg   = '0;
		expData    = '0;
		checkData  = 1'b0;
		mapped     = 1'b0;
		cycleCount = 0;
		errors     = 0;
		testName   = "reset";
		wait (rst == 1'b0);

		repeat (4)
		begin
			outVal = $urandom;
			dirVal = $urandom;
			pinVal = $urandom;
			writeReg("gpio out write", mmioPkg::gpioOutAddr, outVal);
			modelOut <= outVal;
			writeReg("gpio dir write", mmioPkg::gpioDirAddr, dirVal);
			modelDir <= dirVal;
			readCheck("gpio out read", mmioPkg::gpioOutAddr, outVal);
			readCheck("gpio dir read", mmioPkg::gpioDirAddr, dirVal);
			gpioPinsIn <= pinVal;
			readCheck("gpio in read", mmioPkg::gpioInAddr, pinVal & ~dirVal);
		end

		// two misses in a row with a fresh count each
		repeat (2)
		begin
			busAccess("bus miss", unmappedAddr, mmioPkg::opRead, '0, 1'b0, 1'b0, '0,
				ignored);
		end

		busAccess("us counter", mmioPkg::usCountAddr, mmioPkg::opRead, '0, 1'b1, 1'b0,
			'0, usFirst);
		startCycle = cycleCount;
		repeat (4) waitException(digit);
		busAccess("us counter", mmioPkg::usCountAddr, mmioPkg::opRead, '0, 1'b1, 1'b0,
			'0, usSecond);
		ticks = (cycleCount - startCycle) / mmioPkg::usDivide;
		delta = int'(usSecond - usFirst);
		usDelta: assert (delta >= ticks - 1 && delta <= ticks + 1)
			else reportValue("us counter delta", 64'(ticks), 64'(delta));

		segVal = $urandom;
		writeReg("seg value write", mmioPkg::segValueAddr, segVal);
		modelSeg <= segVal;
		readCheck("seg value read", mmioPkg::segValueAddr, segVal);
		testName = "seg scan";
		for (int d = 0; d < 8; d++)
		begin
			hits[d] = 0;
		end
		repeat (8)
		begin
			waitException(digit);
			hits[digit] = hits[digit] + 1;
		end
		for (int d = 0; d < 8; d++)
		begin
			digitOnce: assert (hits[d] == 1)
				else reportValue("digit select count", 64'h1, 64'(hits[d]));
		end

		repeat (2) @(posedge clock);
		$display("run finished after %0d cycles with %0d errors", cycleCount, errors);
		if (errors == 0)
		begin
			$display("Test completed successfully");
		end
		else
		begin
			$display("Test failed");
		end
		$finish;
	end

endmodule
